/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_dcache_top
RTL_TOP   := dcache_top
FILELIST  := dcache_top.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* dcache_top.f */
src/dcache_geom_pkg.sv
src/dcache_ctrl_pkg.sv
src/dcache_way_ram.sv
src/dcache_lookup.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tb/tb_mem_model.sv
tb/tb_dcache_top.sv

/* src/dcache_ctrl.sv */
// data cache controller
// Wishbone slave toward the CPU, master toward memory
module dcache_ctrl #(
    parameter int ADDR_W = dcache_geom_pkg::ADDR_W_DEF,
    parameter int DATA_W = dcache_geom_pkg::DATA_W_DEF,
    parameter int SETS   = dcache_geom_pkg::SETS_DEF
) (
    input  logic                        clk,
    input  logic                        arst_n_i,
    // cpu side
    input  logic                        cpu_cyc_i,
    input  logic                        cpu_stb_i,
    input  logic                        cpu_we_i,
    input  logic [ADDR_W-1:0]           cpu_adr_i,
    input  logic [DATA_W-1:0]           cpu_dat_i,
    input  logic [DATA_W/8-1:0]         cpu_sel_i,
    output logic [DATA_W-1:0]           cpu_dat_o,
    output logic                        cpu_ack_o,
    // memory side
    output logic                        mem_cyc_o,
    output logic                        mem_stb_o,
    output logic                        mem_we_o,
    output logic [ADDR_W-1:0]           mem_adr_o,
    output logic [DATA_W-1:0]           mem_dat_o,
    output logic [DATA_W/8-1:0]         mem_sel_o,
    input  logic [DATA_W-1:0]           mem_dat_i,
    input  logic                        mem_ack_i,
    // lookup and arrays
    output logic [$clog2(SETS)-1:0]     idx_o,
    output logic [ADDR_W-$clog2(SETS)-dcache_geom_pkg::OFFSET_W-1:0] req_tag_o,
    input  logic                        hit_i,
    input  dcache_ctrl_pkg::way_t       hit_way_i,
    input  dcache_ctrl_pkg::way_t       victim_way_i,
    input  logic                        victim_dirty_i,
    input  logic [ADDR_W-$clog2(SETS)-dcache_geom_pkg::OFFSET_W-1:0] victim_tag_i,
    output logic                        touch_o,
    output logic                        fill_o,
    output logic                        mark_dirty_o,
    output dcache_ctrl_pkg::way_t       sel_way_o,
    output logic [1:0]                  tag_we_o,
    output logic [2*(DATA_W/8)-1:0]     data_we_o,
    output logic [DATA_W-1:0]           data_wdata_o,
    input  logic [DATA_W-1:0]           rdata0_i,
    input  logic [DATA_W-1:0]           rdata1_i
);

    localparam int OFFSET_W = dcache_geom_pkg::OFFSET_W;
    localparam int IDX_W    = $clog2(SETS);
    localparam int WORD_W   = ADDR_W - OFFSET_W;
    localparam int LANES    = DATA_W / 8;

    dcache_ctrl_pkg::ctrl_state_e state_q;
    logic                         mem_cyc_q;
    logic [WORD_W-1:0]            word_q;
    logic [DATA_W-1:0]            dat_q;
    logic [LANES-1:0]             sel_q;
    logic                         we_q;
    dcache_ctrl_pkg::way_t        hit_way_q;
    dcache_ctrl_pkg::way_t        victim_q;
    logic [WORD_W-1:0]            wb_word_q;
    logic [DATA_W-1:0]            wb_dat_q;
    logic                         req_valid;
    logic                         refill_done;
    logic [LANES-1:0]             lane_we;

    assign req_valid   = cpu_cyc_i && cpu_stb_i;
    assign refill_done = (state_q == dcache_ctrl_pkg::REFILL) && mem_cyc_q && mem_ack_i;

    // index comes straight from the bus while idle, so the arrays read on the sampling edge.
    assign idx_o = (state_q == dcache_ctrl_pkg::IDLE) ?
                   cpu_adr_i[OFFSET_W +: IDX_W] : word_q[IDX_W-1:0];
    assign req_tag_o = word_q[WORD_W-1:IDX_W];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= dcache_ctrl_pkg::IDLE;
            mem_cyc_q <= 1'b0;
        end else begin
            case (state_q)
                dcache_ctrl_pkg::IDLE: begin
                    if (req_valid) begin
                        state_q <= dcache_ctrl_pkg::LOOKUP;
                    end
                end
                dcache_ctrl_pkg::LOOKUP: begin
                    if (hit_i) begin
                        state_q <= dcache_ctrl_pkg::HIT;
                    end else if (victim_dirty_i) begin
                        state_q   <= dcache_ctrl_pkg::WRBACK;
                        mem_cyc_q <= 1'b1;
                    end else begin
                        state_q <= dcache_ctrl_pkg::REFILL;
                    end
                end
                dcache_ctrl_pkg::WRBACK: begin
                    if (mem_ack_i) begin
                        state_q   <= dcache_ctrl_pkg::REFILL;
                        mem_cyc_q <= 1'b0;
                    end
                end
                dcache_ctrl_pkg::REFILL: begin
                    if (!mem_cyc_q) begin
                        mem_cyc_q <= 1'b1; // read cycle starts.
                    end else if (mem_ack_i) begin
                        state_q   <= dcache_ctrl_pkg::LOOKUP; // retry with the new line.
                        mem_cyc_q <= 1'b0;
                    end
                end
                dcache_ctrl_pkg::HIT: begin
                    state_q <= dcache_ctrl_pkg::IDLE;
                end
                default: begin
                    state_q   <= dcache_ctrl_pkg::IDLE;
                    mem_cyc_q <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == dcache_ctrl_pkg::IDLE && req_valid) begin
            word_q <= cpu_adr_i[ADDR_W-1:OFFSET_W];
            dat_q  <= cpu_dat_i;
            sel_q  <= cpu_sel_i;
            we_q   <= cpu_we_i;
        end
        if (state_q == dcache_ctrl_pkg::LOOKUP) begin
            hit_way_q <= hit_way_i;
            victim_q  <= victim_way_i;
            wb_word_q <= {victim_tag_i, word_q[IDX_W-1:0]};
            wb_dat_q  <= victim_way_i ? rdata1_i : rdata0_i;
        end
    end

    // cpu response.
    assign cpu_ack_o = (state_q == dcache_ctrl_pkg::HIT);
    assign cpu_dat_o = hit_way_q ? rdata1_i : rdata0_i;

    // memory master.
    assign mem_cyc_o = mem_cyc_q;
    assign mem_stb_o = mem_cyc_q;
    assign mem_we_o  = (state_q == dcache_ctrl_pkg::WRBACK);
    assign mem_adr_o = {(mem_we_o ? wb_word_q : word_q), {OFFSET_W{1'b0}}};
    assign mem_dat_o = wb_dat_q;
    assign mem_sel_o = '1;

    // lookup state updates.
    assign touch_o      = (state_q == dcache_ctrl_pkg::HIT);
    assign mark_dirty_o = (state_q == dcache_ctrl_pkg::HIT) && we_q;
    assign fill_o       = refill_done;
    assign sel_way_o    = (state_q == dcache_ctrl_pkg::REFILL) ? victim_q : hit_way_q;

    // array writes, whole line on refill, cpu lanes on a write hit.
    assign lane_we = refill_done ? {LANES{1'b1}} :
                     (mark_dirty_o ? sel_q : '0);

    assign tag_we_o[0] = refill_done && !victim_q;
    assign tag_we_o[1] = refill_done && victim_q;

    assign data_we_o[LANES-1:0]       = (sel_way_o == 1'b0) ? lane_we : '0;
    assign data_we_o[2*LANES-1:LANES] = (sel_way_o == 1'b1) ? lane_we : '0;
    assign data_wdata_o = (state_q == dcache_ctrl_pkg::REFILL) ? mem_dat_i : dat_q;

endmodule

/* src/dcache_ctrl_pkg.sv */
// data cache controller types
package dcache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOOKUP = 3'd1,
        HIT    = 3'd2,
        WRBACK = 3'd3,
        REFILL = 3'd4
    } ctrl_state_e;

    // saturating age, larger means older.
    typedef logic [2:0] age_t;
    localparam age_t AGE_MAX = 3'd7;

    typedef logic way_t; // 0 selects way 0.

endpackage

/* src/dcache_geom_pkg.sv */
// data cache geometry
package dcache_geom_pkg;

    // default geometry, overridden from the top level.
    localparam int ADDR_W_DEF = 32;
    localparam int DATA_W_DEF = 64;
    localparam int SETS_DEF   = 64;

    // byte offset inside one 64-bit word.
    localparam int OFFSET_W = 3;

endpackage

/* src/dcache_lookup.sv */
// set lookup and replacement
module dcache_lookup #(
    parameter int ADDR_W = dcache_geom_pkg::ADDR_W_DEF,
    parameter int SETS   = dcache_geom_pkg::SETS_DEF
) (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic [$clog2(SETS)-1:0]     idx_i,
    input  logic [ADDR_W-$clog2(SETS)-dcache_geom_pkg::OFFSET_W-1:0] req_tag_i,
    input  logic [ADDR_W-$clog2(SETS)-dcache_geom_pkg::OFFSET_W-1:0] tag0_i,
    input  logic [ADDR_W-$clog2(SETS)-dcache_geom_pkg::OFFSET_W-1:0] tag1_i,
    input  logic                        touch_i,
    input  logic                        fill_i,
    input  logic                        mark_dirty_i,
    input  dcache_ctrl_pkg::way_t       sel_way_i,
    output logic                        hit_o,
    output dcache_ctrl_pkg::way_t       hit_way_o,
    output dcache_ctrl_pkg::way_t       victim_way_o,
    output logic                        victim_dirty_o,
    output logic [ADDR_W-$clog2(SETS)-dcache_geom_pkg::OFFSET_W-1:0] victim_tag_o
);

    logic [1:0][SETS-1:0]                       valid_q;
    logic [1:0][SETS-1:0]                       dirty_q;
    dcache_ctrl_pkg::age_t [1:0][SETS-1:0]      age_q;
    logic [1:0]                                 way_hit;
    logic [1:0]                                 set_valid;
    dcache_ctrl_pkg::way_t                      other_way;
    dcache_ctrl_pkg::way_t                      victim;

    assign set_valid[0] = valid_q[0][idx_i];
    assign set_valid[1] = valid_q[1][idx_i];

    assign way_hit[0] = set_valid[0] && (tag0_i == req_tag_i);
    assign way_hit[1] = set_valid[1] && (tag1_i == req_tag_i);

    assign hit_o     = |way_hit;
    assign hit_way_o = dcache_ctrl_pkg::way_t'(way_hit[1]);

    // invalid way first, then the older one; a tie stays on way 0.
    always_comb begin
        if (!set_valid[0]) begin
            victim = 1'b0;
        end else if (!set_valid[1]) begin
            victim = 1'b1;
        end else begin
            victim = dcache_ctrl_pkg::way_t'(age_q[1][idx_i] > age_q[0][idx_i]);
        end
    end

    assign victim_way_o   = victim;
    assign victim_dirty_o = valid_q[victim][idx_i] && dirty_q[victim][idx_i];
    assign victim_tag_o   = victim ? tag1_i : tag0_i;

    assign other_way = dcache_ctrl_pkg::way_t'(~sel_way_i);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
            age_q   <= '0;
        end else begin
            if (fill_i) begin
                valid_q[sel_way_i][idx_i] <= 1'b1;
                dirty_q[sel_way_i][idx_i] <= 1'b0;
            end
            if (mark_dirty_i) begin
                dirty_q[sel_way_i][idx_i] <= 1'b1;
            end
            if (touch_i) begin
                age_q[sel_way_i][idx_i] <= '0;
                if (valid_q[other_way][idx_i] &&
                    age_q[other_way][idx_i] != dcache_ctrl_pkg::AGE_MAX) begin
                    age_q[other_way][idx_i] <= age_q[other_way][idx_i] + 3'd1;
                end
            end
        end
    end

endmodule

/* src/dcache_top.sv */
// two-way write-back data cache
module dcache_top #(
    parameter int ADDR_W = dcache_geom_pkg::ADDR_W_DEF,
    parameter int DATA_W = dcache_geom_pkg::DATA_W_DEF,
    parameter int SETS   = dcache_geom_pkg::SETS_DEF
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                cpu_cyc_i,
    input  logic                cpu_stb_i,
    input  logic                cpu_we_i,
    input  logic [ADDR_W-1:0]   cpu_adr_i,
    input  logic [DATA_W-1:0]   cpu_dat_i,
    input  logic [DATA_W/8-1:0] cpu_sel_i,
    output logic [DATA_W-1:0]   cpu_dat_o,
    output logic                cpu_ack_o,
    output logic                mem_cyc_o,
    output logic                mem_stb_o,
    output logic                mem_we_o,
    output logic [ADDR_W-1:0]   mem_adr_o,
    output logic [DATA_W-1:0]   mem_dat_o,
    output logic [DATA_W/8-1:0] mem_sel_o,
    input  logic [DATA_W-1:0]   mem_dat_i,
    input  logic                mem_ack_i
);

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - IDX_W - dcache_geom_pkg::OFFSET_W;
    localparam int LANES = DATA_W / 8;

    logic [IDX_W-1:0]       idx;
    logic [TAG_W-1:0]       req_tag;
    logic [TAG_W-1:0]       tag0;
    logic [TAG_W-1:0]       tag1;
    logic [TAG_W-1:0]       victim_tag;
    logic                   hit;
    logic                   victim_dirty;
    dcache_ctrl_pkg::way_t  hit_way;
    dcache_ctrl_pkg::way_t  victim_way;
    dcache_ctrl_pkg::way_t  sel_way;
    logic                   touch;
    logic                   fill;
    logic                   mark_dirty;
    logic [1:0]             tag_we;
    logic [2*LANES-1:0]     data_we;
    logic [DATA_W-1:0]      data_wdata;
    logic [DATA_W-1:0]      rdata0;
    logic [DATA_W-1:0]      rdata1;

    dcache_way_ram #(.SETS(SETS), .entry_t(logic [TAG_W-1:0]), .LANES(1)) u_tag0 (
        .clk     (clk),
        .idx_i   (idx),
        .we_i    (tag_we[0]),
        .wdata_i (req_tag),
        .rdata_o (tag0)
    );

    dcache_way_ram #(.SETS(SETS), .entry_t(logic [TAG_W-1:0]), .LANES(1)) u_tag1 (
        .clk     (clk),
        .idx_i   (idx),
        .we_i    (tag_we[1]),
        .wdata_i (req_tag),
        .rdata_o (tag1)
    );

    dcache_way_ram #(.SETS(SETS), .entry_t(logic [DATA_W-1:0]), .LANES(LANES)) u_data0 (
        .clk     (clk),
        .idx_i   (idx),
        .we_i    (data_we[LANES-1:0]),
        .wdata_i (data_wdata),
        .rdata_o (rdata0)
    );

    dcache_way_ram #(.SETS(SETS), .entry_t(logic [DATA_W-1:0]), .LANES(LANES)) u_data1 (
        .clk     (clk),
        .idx_i   (idx),
        .we_i    (data_we[2*LANES-1:LANES]),
        .wdata_i (data_wdata),
        .rdata_o (rdata1)
    );

    dcache_lookup #(.ADDR_W(ADDR_W), .SETS(SETS)) u_lookup (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .idx_i          (idx),
        .req_tag_i      (req_tag),
        .tag0_i         (tag0),
        .tag1_i         (tag1),
        .touch_i        (touch),
        .fill_i         (fill),
        .mark_dirty_i   (mark_dirty),
        .sel_way_i      (sel_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    dcache_ctrl #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .SETS(SETS)) u_ctrl (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .cpu_cyc_i      (cpu_cyc_i),
        .cpu_stb_i      (cpu_stb_i),
        .cpu_we_i       (cpu_we_i),
        .cpu_adr_i      (cpu_adr_i),
        .cpu_dat_i      (cpu_dat_i),
        .cpu_sel_i      (cpu_sel_i),
        .cpu_dat_o      (cpu_dat_o),
        .cpu_ack_o      (cpu_ack_o),
        .mem_cyc_o      (mem_cyc_o),
        .mem_stb_o      (mem_stb_o),
        .mem_we_o       (mem_we_o),
        .mem_adr_o      (mem_adr_o),
        .mem_dat_o      (mem_dat_o),
        .mem_sel_o      (mem_sel_o),
        .mem_dat_i      (mem_dat_i),
        .mem_ack_i      (mem_ack_i),
        .idx_o          (idx),
        .req_tag_o      (req_tag),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .touch_o        (touch),
        .fill_o         (fill),
        .mark_dirty_o   (mark_dirty),
        .sel_way_o      (sel_way),
        .tag_we_o       (tag_we),
        .data_we_o      (data_we),
        .data_wdata_o   (data_wdata),
        .rdata0_i       (rdata0),
        .rdata1_i       (rdata1)
    );

endmodule

/* src/dcache_way_ram.sv */
// cache way array
module dcache_way_ram #(
    parameter int  SETS    = dcache_geom_pkg::SETS_DEF,
    parameter type entry_t = logic [dcache_geom_pkg::DATA_W_DEF-1:0],
    parameter int  LANES   = dcache_geom_pkg::DATA_W_DEF / 8
) (
    input  logic                    clk,
    input  logic [$clog2(SETS)-1:0] idx_i,
    input  logic [LANES-1:0]        we_i,
    input  entry_t                  wdata_i,
    output entry_t                  rdata_o
);

    localparam int LANE_W = $bits(entry_t) / LANES;

    entry_t mem [SETS];
    entry_t merged;
    entry_t rdata_q;

    // old entry with the enabled lanes replaced.
    always_comb begin
        merged = mem[idx_i];
        for (int l = 0; l < LANES; l++) begin
            if (we_i[l]) begin
                merged[l*LANE_W +: LANE_W] = wdata_i[l*LANE_W +: LANE_W];
            end
        end
    end

    // write-first, so a refilled entry is visible on the next lookup.
    always_ff @(posedge clk) begin
        if (|we_i) begin
            mem[idx_i] <= merged;
        end
        rdata_q <= merged;
    end

    assign rdata_o = rdata_q;

endmodule

/* tb/tb_dcache_top.sv */
// data cache testbench
module tb_dcache_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          SETS     = dcache_geom_pkg::SETS_DEF;
    localparam int          IDX_W    = $clog2(SETS);
    localparam int          TAG_W    = 32 - IDX_W - dcache_geom_pkg::OFFSET_W;
    localparam logic [63:0] FILL_KEY = 64'h5a5a_c3c3_0f0f_9669;

    logic        clk;
    logic        arst_n_i;
    logic        cpu_cyc_i;
    logic        cpu_stb_i;
    logic        cpu_we_i;
    logic [31:0] cpu_adr_i;
    logic [63:0] cpu_dat_i;
    logic [7:0]  cpu_sel_i;
    logic [63:0] cpu_dat_o;
    logic        cpu_ack_o;
    logic        mem_cyc_o;
    logic        mem_stb_o;
    logic        mem_we_o;
    logic [31:0] mem_adr_o;
    logic [63:0] mem_dat_o;
    logic [7:0]  mem_sel_o;
    logic [63:0] mem_dat_i;
    logic        mem_ack_i;

    // reference model of the cache state.
    logic [TAG_W-1:0]      ref_tag   [2][SETS];
    logic                  ref_valid [2][SETS];
    logic                  ref_dirty [2][SETS];
    dcache_ctrl_pkg::age_t ref_age   [2][SETS];
    logic [63:0]           ref_data  [2][SETS];
    logic [63:0]           ref_mem   [logic [28:0]];
    logic                  txn_we    [$];
    logic [31:0]           txn_adr   [$];
    logic [63:0]           txn_dat   [$];

    dcache_top dut (.*);

    tb_mem_model #(.FILL_KEY(FILL_KEY)) u_mem (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .cyc_i    (mem_cyc_o),
        .stb_i    (mem_stb_o),
        .we_i     (mem_we_o),
        .adr_i    (mem_adr_o),
        .dat_i    (mem_dat_o),
        .dat_o    (mem_dat_i),
        .ack_o    (mem_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // one entry per completed memory cycle.
    always @(negedge clk) begin
        if (mem_cyc_o && mem_stb_o && mem_ack_i) begin
            txn_we.push_back(mem_we_o);
            txn_adr.push_back(mem_adr_o);
            txn_dat.push_back(mem_dat_o);
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else
            stop_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    endtask

    assert property (@(posedge clk) (!arst_n_i || $past(!arst_n_i))
                     |-> !(cpu_ack_o || mem_cyc_o || mem_stb_o))
        else stop_run("ack or memory request active during or right after reset");

    assert property (@(posedge clk) disable iff (!arst_n_i) mem_cyc_o && !mem_ack_i
                     |=> mem_cyc_o && mem_stb_o && $stable(mem_adr_o) && $stable(mem_we_o))
        else stop_run("memory request changed before it was acked");

    assert property (@(posedge clk) disable iff (!arst_n_i) mem_cyc_o
                     |-> mem_stb_o && mem_sel_o == 8'hff)
        else stop_run("memory request without strobe or with partial byte selects");

    assert property (@(posedge clk) disable iff (!arst_n_i) mem_cyc_o && mem_ack_i
                     |=> !mem_cyc_o && !mem_stb_o)
        else stop_run("memory request still active after its ack");

    function automatic logic [63:0] mem_word(input logic [28:0] word);
        if (ref_mem.exists(word)) begin
            return ref_mem[word];
        end
        return {word, 3'b000, word, 3'b000} ^ FILL_KEY;
    endfunction

    // invalid way first, then the older way.
    function automatic logic victim_of(input logic [IDX_W-1:0] idx);
        if (!ref_valid[0][idx]) begin
            return 1'b0;
        end
        if (!ref_valid[1][idx]) begin
            return 1'b1;
        end
        return ref_age[1][idx] > ref_age[0][idx];
    endfunction

    task automatic access(input logic we, input logic [TAG_W-1:0] tag,
                          input logic [IDX_W-1:0] idx, input logic [63:0] dat,
                          input logic [7:0] sel, input logic want_hit);
        logic [1:0]  hv;
        logic        way;
        logic [31:0] wb_adr;
        logic [63:0] wb_dat;
        int          wb_n;
        int          n;
        hv[0]  = ref_valid[0][idx] && ref_tag[0][idx] == tag;
        hv[1]  = ref_valid[1][idx] && ref_tag[1][idx] == tag;
        way    = hv[1];
        wb_n   = 0;
        wb_adr = '0;
        wb_dat = '0;
        check_eq("predicted hit", 64'(|hv), 64'(want_hit));
        if (hv == 2'b00) begin
            way = victim_of(idx);
            if (ref_valid[way][idx] && ref_dirty[way][idx]) begin
                wb_n   = 1;
                wb_adr = {ref_tag[way][idx], idx, 3'b000};
                wb_dat = ref_data[way][idx];
                ref_mem[wb_adr[31:3]] = wb_dat;
            end
            ref_tag[way][idx]   = tag;
            ref_valid[way][idx] = 1'b1;
            ref_dirty[way][idx] = 1'b0;
            ref_data[way][idx]  = mem_word({tag, idx});
        end
        ref_age[way][idx] = '0;
        if (ref_valid[!way][idx] && ref_age[!way][idx] != 3'd7) begin
            ref_age[!way][idx] = ref_age[!way][idx] + 3'd1; // saturates at 7.
        end
        if (we) begin
            for (int l = 0; l < 8; l++) begin
                if (sel[l]) begin
                    ref_data[way][idx][l*8 +: 8] = dat[l*8 +: 8];
                end
            end
            ref_dirty[way][idx] = 1'b1;
        end
        txn_we.delete();
        txn_adr.delete();
        txn_dat.delete();
        @(posedge clk);
        cpu_cyc_i <= 1'b1;
        cpu_stb_i <= 1'b1;
        cpu_we_i  <= we;
        cpu_adr_i <= {tag, idx, 3'b000};
        cpu_dat_i <= dat;
        cpu_sel_i <= sel;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            assert (n <= 100) else stop_run("no cpu_ack_o within 100 cycles");
        end while (!cpu_ack_o);
        if (!we) begin
            check_eq("cpu_dat_o", cpu_dat_o, ref_data[way][idx]);
        end
        if (hv != 2'b00) begin
            check_eq("hit latency", 64'(n - 1), 64'd2); // counted from the sampling edge.
        end
        check_eq("memory cycle count", 64'(txn_we.size()),
                 64'(wb_n + ((hv == 2'b00) ? 1 : 0)));
        if (wb_n == 1) begin
            check_eq("mem_we_o", 64'(txn_we[0]), 64'd1);
            check_eq("mem_adr_o", 64'(txn_adr[0]), 64'(wb_adr));
            check_eq("mem_dat_o", txn_dat[0], wb_dat);
        end
        if (hv == 2'b00) begin
            check_eq("mem_we_o", 64'(txn_we[wb_n]), 64'd0);
            check_eq("mem_adr_o", 64'(txn_adr[wb_n]), 64'({tag, idx, 3'b000}));
        end
        @(posedge clk);
        cpu_cyc_i <= 1'b0;
        cpu_stb_i <= 1'b0;
        cpu_we_i  <= 1'b0;
    endtask

    initial begin
        arst_n_i  = 1'b0;
        cpu_cyc_i = 1'b0;
        cpu_stb_i = 1'b0;
        cpu_we_i  = 1'b0;
        cpu_adr_i = '0;
        cpu_dat_i = '0;
        cpu_sel_i = '0;
        ref_valid = '{default: 1'b0};
        ref_dirty = '{default: 1'b0};
        ref_age   = '{default: 3'd0};
        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;
        repeat (2) @(posedge clk);
        access(1'b0, 23'd1, 6'd5, '0, '0, 1'b0);
        access(1'b0, 23'd1, 6'd5, '0, '0, 1'b1);
        access(1'b1, 23'd1, 6'd5, 64'h1122_3344_5566_7788, 8'b0011_0101, 1'b1);
        access(1'b0, 23'd1, 6'd5, '0, '0, 1'b1);
        // fill set 9, touch way 0, then a third tag evicts way 1.
        access(1'b0, 23'd2, 6'd9, '0, '0, 1'b0);
        access(1'b0, 23'd3, 6'd9, '0, '0, 1'b0);
        access(1'b0, 23'd2, 6'd9, '0, '0, 1'b1);
        access(1'b0, 23'd4, 6'd9, '0, '0, 1'b0);
        access(1'b0, 23'd2, 6'd9, '0, '0, 1'b1);
        access(1'b0, 23'd3, 6'd9, '0, '0, 1'b0);
        access(1'b0, 23'd6, 6'd5, '0, '0, 1'b0);
        access(1'b0, 23'd7, 6'd5, '0, '0, 1'b0); // dirty tag 1 goes back to memory.
        access(1'b0, 23'd1, 6'd5, '0, '0, 1'b0);
        access(1'b1, 23'd8, 6'd12, 64'hdead_beef_cafe_f00d, 8'hf0, 1'b0);
        access(1'b0, 23'd8, 6'd12, '0, '0, 1'b1);
        access(1'b0, 23'd9, 6'd12, '0, '0, 1'b0);
        access(1'b0, 23'd10, 6'd12, '0, '0, 1'b0);
        access(1'b0, 23'd8, 6'd12, '0, '0, 1'b0);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* tb/tb_mem_model.sv */
// memory slave for the cache testbench
module tb_mem_model #(
    parameter logic [63:0] FILL_KEY = 64'h0
) (
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [31:0] adr_i,
    input  logic [63:0] dat_i,
    output logic [63:0] dat_o,
    output logic        ack_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [63:0] written [logic [28:0]]; // write log, by word address.
    logic [31:0] lfsr_q;
    logic [31:0] step1;
    logic [31:0] step2;
    logic [1:0]  wait_q;
    logic        busy_q;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one step for each delay bit.
    assign step1 = lfsr_next(lfsr_q);
    assign step2 = lfsr_next(step1);

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lfsr_q <= 32'h9bf1;
            wait_q <= '0;
            busy_q <= 1'b0;
            ack_o  <= 1'b0;
            dat_o  <= '0;
        end else if (ack_o) begin
            ack_o  <= 1'b0; // master drops cyc now.
            busy_q <= 1'b0;
        end else if (!busy_q) begin
            if (cyc_i && stb_i) begin
                lfsr_q <= step2;
                wait_q <= {step2[0], step1[0]};
                busy_q <= 1'b1;
            end
        end else if (wait_q != 2'd0) begin
            wait_q <= wait_q - 2'd1;
        end else begin
            ack_o <= 1'b1;
            if (we_i) begin
                written[adr_i[31:3]] = dat_i;
            end else if (written.exists(adr_i[31:3])) begin
                dat_o <= written[adr_i[31:3]];
            end else begin
                dat_o <= {adr_i, adr_i} ^ FILL_KEY; // never written.
            end
        end
    end

endmodule
